// File: rtl/rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// datapath and instruction widths
`define RV_XLEN 64
`define RV_ILEN 32

// first fetch address after reset
`define RV_RESET_PC 64'h0000_0000_8000_0000

// architectural integer registers
`define RV_NREGS 32

`endif

// File: rtl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    // major opcodes, encodings from the base ISA
    typedef enum logic [6:0] {
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP_32     = 7'b0111011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS_B,  // lui
        ALU_MULW
    } alu_op_e;

    typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

    typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

    typedef enum logic [1:0] {NPC_SEQ, NPC_BR, NPC_JAL, NPC_JALR} next_pc_e;

    // values follow funct3 of the branch group
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    typedef enum logic {WB_ALU, WB_MEM} wb_sel_e;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD, MEM_DOUBLE} mem_size_e;

endpackage

`default_nettype wire

// File: rtl/rv_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_consts.svh"

interface rv_ctrl_if import rv_core_pkg::*; ();
    alu_op_e             alu_op;
    logic                word;      // 32-bit result, sign-extended
    src1_sel_e           src1_sel;
    src2_sel_e           src2_sel;
    logic [`RV_XLEN-1:0] imm;
    logic                rf_we;
    wb_sel_e             wb_sel;
    next_pc_e            next_pc;
    br_cond_e            br_cond;
    logic                mem_read;
    logic                mem_write;
    mem_size_e           mem_size;
    logic                mem_unsigned;

    modport decode (output alu_op, word, src1_sel, src2_sel, imm, rf_we, wb_sel,
                    next_pc, br_cond, mem_read, mem_write, mem_size, mem_unsigned);
    modport alu (input alu_op, word, src1_sel, src2_sel, imm);
    modport lsu (input mem_read, mem_write, mem_size, mem_unsigned);
    modport pc (input next_pc, br_cond, imm);
endinterface

`default_nettype wire

// File: rtl/rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_consts.svh"

module rv_decoder import rv_core_pkg::*; (
    input  logic [`RV_ILEN-1:0] inst,
    rv_ctrl_if.decode           ctrl,
    output logic                illegal
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic is_op_imm, is_op, is_op_imm_32, is_op_32;
    logic inst_addi, inst_sltiu, inst_andi, inst_slli, inst_srli, inst_srai;
    logic inst_add, inst_sub, inst_and, inst_or, inst_xor;
    logic inst_slt, inst_sltu, inst_sll, inst_srl, inst_sra;
    logic inst_addw, inst_addiw, inst_mulw;
    logic inst_lui, inst_auipc, inst_jal, inst_jalr;
    logic branch, load, store;
    logic op_imm_any, r_type;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign is_op_imm    = opcode == OPC_OP_IMM;
    assign is_op        = opcode == OPC_OP;
    assign is_op_imm_32 = opcode == OPC_OP_IMM_32;
    assign is_op_32     = opcode == OPC_OP_32;

    assign inst_addi  = is_op_imm && funct3 == 3'b000;
    assign inst_sltiu = is_op_imm && funct3 == 3'b011;
    assign inst_andi  = is_op_imm && funct3 == 3'b111;
    // rv64 shifts carry shamt[5] in funct7[0]
    assign inst_slli  = is_op_imm && funct3 == 3'b001 && funct7[6:1] == 6'b000000;
    assign inst_srli  = is_op_imm && funct3 == 3'b101 && funct7[6:1] == 6'b000000;
    assign inst_srai  = is_op_imm && funct3 == 3'b101 && funct7[6:1] == 6'b010000;

    assign inst_add  = is_op && funct3 == 3'b000 && funct7 == 7'b0000000;
    assign inst_sub  = is_op && funct3 == 3'b000 && funct7 == 7'b0100000;
    assign inst_sll  = is_op && funct3 == 3'b001 && funct7 == 7'b0000000;
    assign inst_slt  = is_op && funct3 == 3'b010 && funct7 == 7'b0000000;
    assign inst_sltu = is_op && funct3 == 3'b011 && funct7 == 7'b0000000;
    assign inst_xor  = is_op && funct3 == 3'b100 && funct7 == 7'b0000000;
    assign inst_srl  = is_op && funct3 == 3'b101 && funct7 == 7'b0000000;
    assign inst_sra  = is_op && funct3 == 3'b101 && funct7 == 7'b0100000;
    assign inst_or   = is_op && funct3 == 3'b110 && funct7 == 7'b0000000;
    assign inst_and  = is_op && funct3 == 3'b111 && funct7 == 7'b0000000;

    assign inst_addw  = is_op_32 && funct3 == 3'b000 && funct7 == 7'b0000000;
    assign inst_mulw  = is_op_32 && funct3 == 3'b000 && funct7 == 7'b0000001;
    assign inst_addiw = is_op_imm_32 && funct3 == 3'b000;

    assign inst_lui   = opcode == OPC_LUI;
    assign inst_auipc = opcode == OPC_AUIPC;
    assign inst_jal   = opcode == OPC_JAL;
    assign inst_jalr  = opcode == OPC_JALR && funct3 == 3'b000;

    assign branch = opcode == OPC_BRANCH && funct3[2:1] != 2'b01;
    assign load   = opcode == OPC_LOAD && funct3 != 3'b111;  // no ldu
    assign store  = opcode == OPC_STORE && !funct3[2];

    assign op_imm_any = inst_addi | inst_sltiu | inst_andi | inst_slli | inst_srli | inst_srai;
    assign r_type = inst_add | inst_sub | inst_and | inst_or | inst_xor | inst_slt | inst_sltu
                  | inst_sll | inst_srl | inst_sra | inst_addw | inst_mulw;

    // anything unmatched halts the core, divw included
    assign illegal = ~(op_imm_any | r_type | inst_addiw | inst_lui | inst_auipc | inst_jal
                     | inst_jalr | branch | load | store);

    assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21],
                    1'b0};

    assign ctrl.imm = store ? imm_s :
                      branch ? imm_b :
                      (inst_lui | inst_auipc) ? imm_u :
                      inst_jal ? imm_j : imm_i;

    always_comb begin
        ctrl.alu_op = ALU_ADD;  // adds, address and link
        if (inst_sub)                    ctrl.alu_op = ALU_SUB;
        else if (inst_slt)               ctrl.alu_op = ALU_SLT;
        else if (inst_sltu | inst_sltiu) ctrl.alu_op = ALU_SLTU;
        else if (inst_and | inst_andi)   ctrl.alu_op = ALU_AND;
        else if (inst_or)                ctrl.alu_op = ALU_OR;
        else if (inst_xor)               ctrl.alu_op = ALU_XOR;
        else if (inst_sll | inst_slli)   ctrl.alu_op = ALU_SLL;
        else if (inst_srl | inst_srli)   ctrl.alu_op = ALU_SRL;
        else if (inst_sra | inst_srai)   ctrl.alu_op = ALU_SRA;
        else if (inst_lui)               ctrl.alu_op = ALU_PASS_B;
        else if (inst_mulw)              ctrl.alu_op = ALU_MULW;
    end

    assign ctrl.word     = inst_addw | inst_addiw | inst_mulw;
    assign ctrl.src1_sel = (inst_auipc | inst_jal | inst_jalr) ? SRC1_PC : SRC1_RS1;
    assign ctrl.src2_sel = (inst_jal | inst_jalr) ? SRC2_FOUR :
                           r_type ? SRC2_RS2 : SRC2_IMM;
    assign ctrl.rf_we    = op_imm_any | r_type | inst_addiw | inst_lui | inst_auipc
                         | inst_jal | inst_jalr | load;
    assign ctrl.wb_sel   = load ? WB_MEM : WB_ALU;
    assign ctrl.next_pc  = branch ? NPC_BR :
                           inst_jal ? NPC_JAL :
                           inst_jalr ? NPC_JALR : NPC_SEQ;
    assign ctrl.br_cond      = br_cond_e'(funct3);
    assign ctrl.mem_read     = load;
    assign ctrl.mem_write    = store;
    assign ctrl.mem_size     = mem_size_e'(funct3[1:0]);
    assign ctrl.mem_unsigned = funct3[2];
endmodule

`default_nettype wire

// File: rtl/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_consts.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data,
    input  logic                rd_we,
    input  logic [4:0]          rd_addr,
    input  logic [`RV_XLEN-1:0] rd_data
);
    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != 5'd0) begin  // x0 never written
            regs[rd_addr] <= rd_data;
        end
    end

    // async read ports
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
endmodule

`default_nettype wire

// File: rtl/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_consts.svh"

module rv_alu import rv_core_pkg::*; (
    rv_ctrl_if.alu              ctrl,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    output logic [`RV_XLEN-1:0] result
);
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] raw;
    logic [5:0]          shamt;
    logic signed [63:0]  prod;

    assign op_a = (ctrl.src1_sel == SRC1_PC) ? pc : rs1_data;

    always_comb begin
        case (ctrl.src2_sel)
            SRC2_RS2:  op_b = rs2_data;
            SRC2_IMM:  op_b = ctrl.imm;
            SRC2_FOUR: op_b = `RV_XLEN'd4;  // link address
            default:   op_b = rs2_data;
        endcase
    end

    assign shamt = op_b[5:0];
    // only the low word of the product is kept
    assign prod  = $signed(op_a[31:0]) * $signed(op_b[31:0]);

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    raw = op_a + op_b;
            ALU_SUB:    raw = op_a - op_b;
            ALU_SLT:    raw = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   raw = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_AND:    raw = op_a & op_b;
            ALU_OR:     raw = op_a | op_b;
            ALU_XOR:    raw = op_a ^ op_b;
            ALU_SLL:    raw = op_a << shamt;
            ALU_SRL:    raw = op_a >> shamt;
            ALU_SRA:    raw = $signed(op_a) >>> shamt;
            ALU_PASS_B: raw = op_b;
            ALU_MULW:   raw = prod;
            default:    raw = op_a + op_b;
        endcase
    end

    // w-forms keep bits 31:0 and sign-extend
    assign result = ctrl.word ? {{(`RV_XLEN-32){raw[31]}}, raw[31:0]} : raw;
endmodule

`default_nettype wire

// File: rtl/rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_consts.svh"

module rv_lsu import rv_core_pkg::*; (
    rv_ctrl_if.lsu              ctrl,
    input  logic [`RV_XLEN-1:0] addr,
    input  logic [`RV_XLEN-1:0] store_data,
    output logic [`RV_XLEN-1:0] dmem_wdata,
    output logic [7:0]          dmem_wstrb,
    input  logic [`RV_XLEN-1:0] dmem_rdata,
    output logic [`RV_XLEN-1:0] load_data
);
    logic [2:0]          offset;
    logic [7:0]          size_mask;
    logic [`RV_XLEN-1:0] lane;
    logic [`RV_XLEN-1:0] extended;

    assign offset = addr[2:0];

    // replicate so every lane holds the value, strobes pick the one written
    always_comb begin
        case (ctrl.mem_size)
            MEM_BYTE: begin
                dmem_wdata = {8{store_data[7:0]}};
                size_mask  = 8'b0000_0001;
            end
            MEM_HALF: begin
                dmem_wdata = {4{store_data[15:0]}};
                size_mask  = 8'b0000_0011;
            end
            MEM_WORD: begin
                dmem_wdata = {2{store_data[31:0]}};
                size_mask  = 8'b0000_1111;
            end
            default: begin
                dmem_wdata = store_data;
                size_mask  = 8'b1111_1111;
            end
        endcase
    end

    assign dmem_wstrb = ctrl.mem_write ? size_mask << offset : 8'b0;

    assign lane = dmem_rdata >> {offset, 3'b000};  // addressed byte to bit 0

    always_comb begin
        case (ctrl.mem_size)
            MEM_BYTE: extended = ctrl.mem_unsigned ? {56'b0, lane[7:0]}  : {{56{lane[7]}}, lane[7:0]};
            MEM_HALF: extended = ctrl.mem_unsigned ? {48'b0, lane[15:0]} : {{48{lane[15]}}, lane[15:0]};
            MEM_WORD: extended = ctrl.mem_unsigned ? {32'b0, lane[31:0]} : {{32{lane[31]}}, lane[31:0]};
            default:  extended = lane;
        endcase
    end

    assign load_data = ctrl.mem_read ? extended : '0;
endmodule

`default_nettype wire

// File: rtl/rv_pc_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_consts.svh"

module rv_pc_unit import rv_core_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    rv_ctrl_if.pc               ctrl,
    input  logic                illegal,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    input  logic [`RV_XLEN-1:0] jalr_base,
    output logic [`RV_XLEN-1:0] pc,
    output logic                halted
);
    logic                taken;
    logic [`RV_XLEN-1:0] pc_seq;
    logic [`RV_XLEN-1:0] pc_rel;
    logic [`RV_XLEN-1:0] jalr_sum;
    logic [`RV_XLEN-1:0] pc_next;

    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   taken = rs1_data == rs2_data;
            BR_NE:   taken = rs1_data != rs2_data;
            BR_LT:   taken = $signed(rs1_data) < $signed(rs2_data);
            BR_GE:   taken = $signed(rs1_data) >= $signed(rs2_data);
            BR_LTU:  taken = rs1_data < rs2_data;
            BR_GEU:  taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    assign pc_seq   = pc + `RV_XLEN'd4;
    assign pc_rel   = pc + ctrl.imm;
    assign jalr_sum = jalr_base + ctrl.imm;

    always_comb begin
        case (ctrl.next_pc)
            NPC_BR:   pc_next = taken ? pc_rel : pc_seq;
            NPC_JAL:  pc_next = pc_rel;
            NPC_JALR: pc_next = {jalr_sum[`RV_XLEN-1:1], 1'b0};
            default:  pc_next = pc_seq;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= `RV_RESET_PC;
            halted <= 1'b0;
        end else begin
            if (!illegal) pc <= pc_next;  // freeze on the bad word
            if (illegal) halted <= 1'b1;  // sticky until reset
        end
    end
endmodule

`default_nettype wire

// File: rtl/rv_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_consts.svh"

module rv_core import rv_core_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_ILEN-1:0] imem_rdata,
    output logic [`RV_XLEN-1:0] dmem_addr,
    output logic [`RV_XLEN-1:0] dmem_wdata,
    output logic [7:0]          dmem_wstrb,
    output logic                dmem_we,
    output logic                dmem_re,
    input  logic [`RV_XLEN-1:0] dmem_rdata,
    output logic                illegal
);
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] rd_data;
    logic [7:0]          lsu_wstrb;
    logic                dec_illegal;
    logic                halted;
    logic                rd_we;

    rv_ctrl_if ctrl ();

    rv_decoder u_decoder (
        .inst    (imem_rdata),
        .ctrl    (ctrl.decode),
        .illegal (dec_illegal)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (imem_rdata[19:15]),
        .rs2_addr (imem_rdata[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_we    (rd_we),
        .rd_addr  (imem_rdata[11:7]),
        .rd_data  (rd_data)
    );

    rv_alu u_alu (
        .ctrl     (ctrl.alu),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result)
    );

    rv_lsu u_lsu (
        .ctrl       (ctrl.lsu),
        .addr       (alu_result),
        .store_data (rs2_data),
        .dmem_wdata (dmem_wdata),
        .dmem_wstrb (lsu_wstrb),
        .dmem_rdata (dmem_rdata),
        .load_data  (load_data)
    );

    rv_pc_unit u_pc_unit (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl.pc),
        .illegal   (dec_illegal),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .jalr_base (rs1_data),
        .pc        (pc),
        .halted    (halted)
    );

    assign illegal = dec_illegal | halted;

    // no side effects once halted
    assign rd_we      = ctrl.rf_we & ~illegal;
    assign dmem_we    = ctrl.mem_write & ~illegal;
    assign dmem_re    = ctrl.mem_read & ~illegal;
    assign dmem_wstrb = dmem_we ? lsu_wstrb : 8'b0;

    assign rd_data   = (ctrl.wb_sel == WB_MEM) ? load_data : alu_result;
    assign imem_addr = pc;
    assign dmem_addr = alu_result;  // full byte address
endmodule

`default_nettype wire

// File: dv/rv_core_tb_clk.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb_clk (
    output logic clk
);
    initial clk = 1'b0;

    always #4 clk = ~clk;  // 8 ns period
endmodule

`default_nettype wire

// File: dv/rv_core_assert.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_consts.svh"

module rv_core_assert (
    input logic                clk,
    input logic                arst_n,
    input logic [`RV_XLEN-1:0] imem_addr,
    input logic                dmem_we,
    input logic                dmem_re,
    input logic [7:0]          dmem_wstrb,
    input logic                illegal
);
    no_rw_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        !(dmem_we && dmem_re))
        else $error("dmem_we and dmem_re high together");

    // halted core keeps its pc and writes nothing
    halt_pc_frozen: assert property (@(posedge clk) disable iff (!arst_n)
        illegal |=> $stable(imem_addr))
        else $error("imem_addr moved after illegal");

    halt_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        illegal |=> illegal && !dmem_we)
        else $error("illegal dropped or dmem_we rose after halt");

    // strobes exactly when a store commits
    strb_match: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_we == (dmem_wstrb != 8'b0))
        else $error("dmem_wstrb does not match dmem_we");
endmodule

bind rv_core rv_core_assert u_assert (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .dmem_wstrb (dmem_wstrb),
    .illegal    (illegal)
);

`default_nettype wire

// File: dv/rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_consts.svh"

module rv_core_tb import rv_core_pkg::*; ();
    logic        clk;
    logic        arst_n;
    logic [63:0] imem_addr, dmem_addr, dmem_wdata, dmem_rdata;
    logic [31:0] imem_rdata;
    logic [7:0]  dmem_wstrb;
    logic        dmem_we, dmem_re, illegal;
    logic [31:0] imem [256];
    logic [63:0] dmem [256];
    logic [63:0] exp_d [64];
    logic [31:0] lfsr = 32'h3d17bd4c;
    int          pidx, loop_idx, tests, fails, test_errs;

    rv_core_tb_clk u_clk (.clk(clk));

    rv_core dut (
        .clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb),
        .dmem_we(dmem_we), .dmem_re(dmem_re), .dmem_rdata(dmem_rdata), .illegal(illegal)
    );

    assign imem_rdata = imem[8'((imem_addr - `RV_RESET_PC) >> 2)];
    // aligned doubleword, inverted when dmem_re is low
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[10:3]] : ~dmem[dmem_addr[10:3]];

    always @(posedge clk) begin
        if (dmem_we) begin
            for (int b = 0; b < 8; b++) begin
                if (dmem_wstrb[b]) dmem[dmem_addr[10:3]][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [63:0] fill_value(input logic [31:0] i);
        return {~i * 32'h9e3779b9, (i * 32'h01000193) ^ 32'h5a5a5a5a};
    endfunction

    function automatic logic [63:0] pc_of(input int idx);
        return `RV_RESET_PC + 64'(idx) * 4;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input opcode_e op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input opcode_e op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[pidx] = w;
        pidx++;
    endtask

    task automatic load_imm(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12;
        emit(enc_u(upper[19:0], rd, OPC_LUI));
        emit(enc_i(v[11:0], rd, 3'b000, rd, OPC_OP_IMM_32));  // addiw
    endtask

    task automatic store_res(input int slot);
        emit(enc_s(12'(slot * 8), 5'd3, 5'd0, 3'b011));  // sd x3
    endtask

    task automatic begin_prog();
        @(posedge clk);
        arst_n <= 1'b0;  // core held idle while the memories are rewritten
        @(negedge clk);
        pidx = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0;
            dmem[i] = fill_value(i);
        end
        for (int i = 0; i < 64; i++) exp_d[i] = fill_value(i);
    endtask

    task automatic release_reset();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic wait_for(input bit want_illegal, input logic [63:0] addr);
        bit hit;
        hit = 1'b0;
        for (int n = 0; n < 200 && !hit; n++) begin
            @(negedge clk);
            hit = want_illegal ? illegal : (imem_addr == addr);
        end
        if (!hit) begin
            $display("timeout at %0t: core never reached the expected state", $time);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    task automatic run_prog();
        loop_idx = pidx;
        emit(enc_j(21'd0, 5'd0));  // self-loop
        release_reset();
        wait_for(1'b0, pc_of(loop_idx));
    endtask

    task automatic check_all(input string name);
        for (int i = 0; i < 64; i++) begin
            assert (dmem[i] === exp_d[i])
            else begin
                $display("[FAIL] %0t %s: slot %0d got %h expected %h", $time, name, i,
                         dmem[i], exp_d[i]);
                test_errs++;
            end
        end
        $display("test %s: %s", name, test_errs == 0 ? "passed" : "failed");
        tests++;
        if (test_errs != 0) fails++;
        test_errs = 0;
    endtask

    task automatic r_op(input logic [6:0] f7, input logic [2:0] f3, input opcode_e op,
                        input int slot, input logic [63:0] e);
        emit(enc_r(f7, 5'd2, 5'd1, f3, 5'd3, op));
        store_res(slot);
        exp_d[slot] = e;
    endtask

    task automatic i_op(input logic [11:0] imm, input logic [2:0] f3, input opcode_e op,
                        input int slot, input logic [63:0] e);
        emit(enc_i(imm, 5'd1, f3, 5'd3, op));
        store_res(slot);
        exp_d[slot] = e;
    endtask

    task automatic test_alu();
        logic [63:0] a, b, ie;
        logic [11:0] im;
        logic [5:0]  sh;
        begin_prog();
        a = sext32(take_bits(32));
        b = sext32(take_bits(32));
        im = 12'(take_bits(12));
        sh = 6'(take_bits(6));
        ie = {{52{im[11]}}, im};
        load_imm(1, a[31:0]);
        load_imm(2, b[31:0]);
        r_op(7'h00, 3'b000, OPC_OP, 0, a + b);
        r_op(7'h20, 3'b000, OPC_OP, 1, a - b);
        r_op(7'h00, 3'b001, OPC_OP, 2, a << b[5:0]);
        r_op(7'h00, 3'b010, OPC_OP, 3, {63'b0, $signed(a) < $signed(b)});
        r_op(7'h00, 3'b011, OPC_OP, 4, {63'b0, a < b});
        r_op(7'h00, 3'b100, OPC_OP, 5, a ^ b);
        r_op(7'h00, 3'b101, OPC_OP, 6, a >> b[5:0]);
        r_op(7'h20, 3'b101, OPC_OP, 7, $signed(a) >>> b[5:0]);
        r_op(7'h00, 3'b110, OPC_OP, 8, a | b);
        r_op(7'h00, 3'b111, OPC_OP, 9, a & b);
        i_op(im, 3'b000, OPC_OP_IMM, 10, a + ie);
        i_op(im, 3'b011, OPC_OP_IMM, 11, {63'b0, a < ie});
        i_op(im, 3'b111, OPC_OP_IMM, 12, a & ie);
        i_op({6'b000000, sh}, 3'b001, OPC_OP_IMM, 13, a << sh);
        i_op({6'b000000, sh}, 3'b101, OPC_OP_IMM, 14, a >> sh);
        i_op({6'b010000, sh}, 3'b101, OPC_OP_IMM, 15, $signed(a) >>> sh);
        emit(enc_i(12'h123, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));  // write to x0
        emit(enc_s(12'(16 * 8), 5'd0, 5'd0, 3'b011));
        exp_d[16] = 64'h0;
        run_prog();
        check_all("alu");
    endtask

    task automatic test_word();
        logic [63:0] a, b, ie;
        logic [11:0] im;
        begin_prog();
        a = sext32(take_bits(32));
        b = sext32(take_bits(32));
        im = 12'(take_bits(12));
        ie = {{52{im[11]}}, im};
        load_imm(1, a[31:0]);
        load_imm(2, b[31:0]);
        r_op(7'h00, 3'b000, OPC_OP_32, 0, sext32(a[31:0] + b[31:0]));
        i_op(im, 3'b000, OPC_OP_IMM_32, 1, sext32(a[31:0] + ie[31:0]));
        r_op(7'h01, 3'b000, OPC_OP_32, 2, sext32(a[31:0] * b[31:0]));
        load_imm(1, 32'h7fffffff);
        load_imm(2, 32'h00000001);
        r_op(7'h00, 3'b000, OPC_OP_32, 3, 64'hffffffff_80000000);  // overflow into bit 31
        r_op(7'h01, 3'b000, OPC_OP_32, 4, 64'h00000000_7fffffff);
        run_prog();
        check_all("word");
    endtask

    task automatic test_jump();
        logic [19:0] u;
        logic [31:0] marker;
        int          idx;
        begin_prog();
        u = 20'(take_bits(20));
        marker = take_bits(32) | 32'h1;
        load_imm(1, marker);
        emit(enc_u(u, 5'd3, OPC_LUI));
        store_res(0);
        exp_d[0] = sext32({u, 12'b0});
        idx = pidx;
        emit(enc_u(u, 5'd3, OPC_AUIPC));
        store_res(1);
        exp_d[1] = pc_of(idx) + sext32({u, 12'b0});
        idx = pidx;
        emit(enc_j(21'd8, 5'd5));
        emit(enc_s(12'(2 * 8), 5'd1, 5'd0, 3'b011));  // skipped
        emit(enc_s(12'(3 * 8), 5'd5, 5'd0, 3'b011));
        exp_d[3] = pc_of(idx) + 4;
        idx = pidx;
        emit(enc_u(20'h0, 5'd6, OPC_AUIPC));
        emit(enc_i(12'd13, 5'd6, 3'b000, 5'd7, OPC_JALR));  // bit 0 dropped
        emit(enc_s(12'(4 * 8), 5'd1, 5'd0, 3'b011));  // skipped
        emit(enc_s(12'(5 * 8), 5'd7, 5'd0, 3'b011));
        exp_d[5] = pc_of(idx + 1) + 4;
        run_prog();
        check_all("jump");
    endtask

    task automatic test_branch();
        logic [2:0]  codes [6];
        logic [63:0] a, b, x, y;
        logic [31:0] marker;
        logic        taken;
        int          slot;
        begin_prog();
        codes = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        marker = take_bits(32) | 32'h1;
        load_imm(9, marker);
        slot = 0;
        for (int c = 0; c < 6; c++) begin
            a = sext32(take_bits(32));
            b = sext32(take_bits(32));
            if (b == a) b = ~a;
            for (int k = 0; k < 2; k++) begin
                x = (c >= 2 && k == 1) ? b : a;
                y = (c < 2) ? (k == 1 ? b : a) : (k == 1 ? a : b);
                case (codes[c])
                    3'b000:  taken = x == y;
                    3'b001:  taken = x != y;
                    3'b100:  taken = $signed(x) < $signed(y);
                    3'b101:  taken = $signed(x) >= $signed(y);
                    3'b110:  taken = x < y;
                    default: taken = x >= y;
                endcase
                load_imm(1, x[31:0]);
                load_imm(2, y[31:0]);
                emit(enc_b(13'd8, 5'd2, 5'd1, codes[c]));
                emit(enc_s(12'(slot * 8), 5'd9, 5'd0, 3'b011));  // marker on the not-taken path
                if (!taken) exp_d[slot] = sext32(marker);
                slot++;
            end
        end
        run_prog();
        check_all("branch");
    endtask

    task automatic test_mem();
        logic [63:0] d, e, lane;
        int          slot, w;
        begin_prog();
        d = sext32(take_bits(32));
        load_imm(1, d[31:0]);
        slot = 0;
        for (int sz = 0; sz < 4; sz++) begin
            for (int off = 0; off < 8; off += (1 << sz)) begin
                emit(enc_s(12'(slot * 8 + off), 5'd1, 5'd0, 3'(sz)));
                e = fill_value(slot);
                for (int bt = 0; bt < (1 << sz); bt++) e[8*(off+bt) +: 8] = d[8*bt +: 8];
                exp_d[slot] = e;
                slot++;
            end
        end
        slot = 24;
        for (int sz = 0; sz < 4; sz++) begin
            for (int uns = 0; uns < (sz == 3 ? 1 : 2); uns++) begin
                for (int off = 0; off < 8; off += (1 << sz)) begin
                    emit(enc_i(12'(20 * 8 + off), 5'd0, {1'(uns), 2'(sz)}, 5'd3, OPC_LOAD));
                    store_res(slot);
                    lane = fill_value(20) >> (8 * off);
                    w = 8 << sz;
                    e = lane;
                    for (int i = w; i < 64; i++) e[i] = (uns == 1) ? 1'b0 : lane[w-1];
                    exp_d[slot] = e;
                    slot++;
                end
            end
        end
        run_prog();
        check_all("mem");
    endtask

    task automatic test_illegal();
        logic [63:0] addr;
        begin_prog();
        load_imm(1, take_bits(32) | 32'h1);
        emit(enc_r(7'h01, 5'd2, 5'd1, 3'b100, 5'd3, OPC_OP_32));  // divw
        emit(enc_s(12'h0, 5'd1, 5'd0, 3'b011));
        emit(enc_j(21'd0, 5'd0));
        release_reset();
        wait_for(1'b1, 64'h0);
        addr = imem_addr;
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            assert (illegal && imem_addr == addr)
            else begin
                $display("[FAIL] %0t illegal: illegal %b pc %h held %h", $time, illegal,
                         imem_addr, addr);
                test_errs++;
            end
        end
        check_all("illegal");
    endtask

    initial begin
        arst_n = 1'b0;
        tests = 0;
        fails = 0;
        test_errs = 0;
        test_alu();
        test_word();
        test_jump();
        test_branch();
        test_mem();
        test_illegal();
        $display("tests run %0d, tests failed %0d", tests, fails);
        if (fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: rv_core.f
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rv_ctrl_if.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_lsu.sv
rtl/rv_pc_unit.sv
rtl/rv_core.sv
dv/rv_core_tb_clk.sv
dv/rv_core_assert.sv
dv/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FLIST     ?= rv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
